//--- include/io_defs.svh
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// --------------------------------------------------
// I/O space map
// --------------------------------------------------

// Top four address bits select the region
`define IO_REGION        4'hC

// Word offsets inside the region, low two bits always zero
`define IO_OFS_LED       28'h000_0000
`define IO_OFS_TMR       28'h000_0004
`define IO_OFS_SPI_CTRL  28'h000_0020
`define IO_OFS_SPI_DATA  28'h000_0024

// --------------------------------------------------
// Reset values and timing
// --------------------------------------------------

// Top LED lit out of reset
`define LED_RESET        3'b100

// clk_48 cycles per microsecond tick
`define TMR_PRESCALE     48

`endif

//--- rtl/io_pkg.sv
`default_nettype none

package io_pkg;

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------

    typedef logic [31:0] io_addr_t;
    typedef logic [31:0] io_data_t;
    typedef logic [2:0]  led_bits_t;
    typedef logic [31:0] tmr_count_t;
    typedef logic [7:0]  spi_byte_t;

    // --------------------------------------------------
    // Bus and status bundles
    // --------------------------------------------------

    // One CPU I/O bus cycle
    typedef struct packed {
        logic     addr_strobe;
        logic     read_strobe;
        logic     write_strobe;
        io_addr_t address;
        io_data_t write_data;
    } io_req_t;

    // Decoded register writes, one enable per register
    typedef struct packed {
        logic     led_we;
        logic     spi_ctrl_we;
        logic     spi_data_we;
        io_data_t wdata;
    } reg_wr_t;

    typedef struct packed {
        led_bits_t  led;
        tmr_count_t tmr;
    } sys_status_t;

    // rx_data also holds the byte being shifted while busy
    typedef struct packed {
        logic      cs;
        logic      busy;
        spi_byte_t rx_data;
    } spi_status_t;

endpackage

`default_nettype wire

//--- rtl/io_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "io_defs.svh"

module io_decoder
    import io_pkg::*;
(
    input  wire         clk_48,
    input  wire         rst_n,

    input  wire io_req_t io_req,

    output reg_wr_t     reg_wr,
    input  wire sys_status_t sys_status,
    input  wire spi_status_t spi_status,

    output logic        io_ready,
    output io_data_t    io_read_data
);

    logic        region_hit;
    logic        access;
    logic        wr_access;
    logic        rd_access;
    logic [27:0] io_ofs;
    io_data_t    rd_mux;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------

    assign region_hit = io_req.address[31:28] == `IO_REGION;

    // Byte lanes ignored, every register is word aligned
    assign io_ofs = {io_req.address[27:2], 2'b00};

    assign access    = io_req.addr_strobe && region_hit &&
                       (io_req.read_strobe || io_req.write_strobe);
    assign wr_access = io_req.addr_strobe && region_hit && io_req.write_strobe;
    assign rd_access = io_req.addr_strobe && region_hit && io_req.read_strobe;

    // Write enables go out in the strobe cycle
    always_comb begin
        reg_wr             = '0;
        reg_wr.wdata       = io_req.write_data;
        reg_wr.led_we      = wr_access && (io_ofs == `IO_OFS_LED);
        reg_wr.spi_ctrl_we = wr_access && (io_ofs == `IO_OFS_SPI_CTRL);
        reg_wr.spi_data_we = wr_access && (io_ofs == `IO_OFS_SPI_DATA);
    end

    // --------------------------------------------------
    // Read data
    // --------------------------------------------------

    always_comb begin
        case (io_ofs)
            `IO_OFS_LED: begin
                rd_mux = io_data_t'(sys_status.led);
            end
            `IO_OFS_TMR: begin
                rd_mux = io_data_t'(sys_status.tmr);
            end
            `IO_OFS_SPI_CTRL: begin
                rd_mux = {30'b0, spi_status.busy, spi_status.cs};
            end
            `IO_OFS_SPI_DATA: begin
                rd_mux = io_data_t'(spi_status.rx_data);
            end
            // Holes in the map read as zero
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    always_ff @(posedge clk_48) begin
        if (rd_access) begin
            io_read_data <= rd_mux;
        end
    end

    // --------------------------------------------------
    // Ready, one clock after the strobe
    // --------------------------------------------------

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            io_ready <= 1'b0;
        end else begin
            io_ready <= access;
        end
    end

endmodule

`default_nettype wire

//--- rtl/sys_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "io_defs.svh"

module sys_regs
    import io_pkg::*;
(
    input  wire          clk_48,
    input  wire          rst_n,

    input  wire reg_wr_t reg_wr,
    output sys_status_t  sys_status
);

    localparam logic [5:0] PRESCALE_LAST = 6'(`TMR_PRESCALE - 1);

    led_bits_t   led_bits;
    tmr_count_t  tmr_count;
    logic [5:0]  tmr_prescale;

    // --------------------------------------------------
    // LED register
    // --------------------------------------------------

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            led_bits <= `LED_RESET;
        end else if (reg_wr.led_we) begin
            led_bits <= reg_wr.wdata[2:0];
        end
    end

    // --------------------------------------------------
    // Microsecond timer
    // --------------------------------------------------

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            tmr_prescale <= '0;
            tmr_count    <= '0;
        end else begin
            if (tmr_prescale == PRESCALE_LAST) begin
                tmr_prescale <= '0;
                // Wraps silently after about 71 minutes
                tmr_count    <= tmr_count + 1'b1;
            end else begin
                tmr_prescale <= tmr_prescale + 1'b1;
            end
        end
    end

    assign sys_status.led = led_bits;
    assign sys_status.tmr = tmr_count;

endmodule

`default_nettype wire

//--- rtl/spi_master.sv
`timescale 1ns/100ps
`default_nettype none

module spi_master
    import io_pkg::*;
(
    input  wire          clk_48,
    input  wire          rst_n,

    input  wire reg_wr_t reg_wr,
    output spi_status_t  spi_status,

    output logic         spi_cs,
    output logic         spi_clk,
    output logic         spi_mosi,
    input  wire          spi_miso
);

    spi_byte_t   shift_reg;
    logic [3:0]  bit_cnt;
    logic        bit_start;

    // A new bit begins only from the high phase of the clock
    assign bit_start = spi_clk && (bit_cnt != 4'd0);

    // --------------------------------------------------
    // Chip select, clock and bit counter
    // --------------------------------------------------

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            spi_cs   <= 1'b1;
            spi_clk  <= 1'b1;
            spi_mosi <= 1'b1;
            bit_cnt  <= 4'd0;
        end else begin
            if (reg_wr.spi_ctrl_we) begin
                spi_cs <= reg_wr.wdata[0];
            end
            if (reg_wr.spi_data_we) begin
                bit_cnt <= 4'd8;
            end

            if (bit_start) begin
                spi_mosi <= shift_reg[7];
                spi_clk  <= 1'b0;
                bit_cnt  <= bit_cnt - 1'b1;
            end

            // Low phase lasts one cycle
            if (!spi_clk) begin
                spi_clk <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Shift register, MSB out first, miso in at bit 0
    // --------------------------------------------------

    always_ff @(posedge clk_48) begin
        if (reg_wr.spi_data_we) begin
            shift_reg <= reg_wr.wdata[7:0];
        end
        if (bit_start) begin
            shift_reg <= {shift_reg[6:0], 1'b0};
        end
        if (!spi_clk) begin
            shift_reg[0] <= spi_miso;
        end
    end

    assign spi_status.cs      = spi_cs;
    assign spi_status.busy    = (bit_cnt != 4'd0) || !spi_clk;
    assign spi_status.rx_data = shift_reg;

endmodule

`default_nettype wire

//--- rtl/cpu_io_block.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_io_block
    import io_pkg::*;
(
    input  wire          clk_48,
    input  wire          rst_n,

    // CPU I/O bus
    input  wire io_req_t io_req,
    output logic         io_ready,
    output io_data_t     io_read_data,

    output led_bits_t    led,

    output logic         spi_cs,
    output logic         spi_clk,
    output logic         spi_mosi,
    input  wire          spi_miso
);

    reg_wr_t     reg_wr;
    sys_status_t sys_status;
    spi_status_t spi_status;

    // --------------------------------------------------
    // Bus decode
    // --------------------------------------------------

    io_decoder i_io_decoder (
        .clk_48       (clk_48),
        .rst_n        (rst_n),
        .io_req       (io_req),
        .reg_wr       (reg_wr),
        .sys_status   (sys_status),
        .spi_status   (spi_status),
        .io_ready     (io_ready),
        .io_read_data (io_read_data)
    );

    // --------------------------------------------------
    // Peripherals
    // --------------------------------------------------

    sys_regs i_sys_regs (
        .clk_48     (clk_48),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .sys_status (sys_status)
    );

    spi_master i_spi_master (
        .clk_48     (clk_48),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .spi_status (spi_status),
        .spi_cs     (spi_cs),
        .spi_clk    (spi_clk),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

    assign led = sys_status.led;

endmodule

`default_nettype wire

//--- test/tb_cpu_io_block.sv
`timescale 1ns/100ps
`default_nettype none

`include "io_defs.svh"

module tb_cpu_io_block
    import io_pkg::*;
();

    localparam io_addr_t ADDR_LED      = {`IO_REGION, `IO_OFS_LED};
    localparam io_addr_t ADDR_TMR      = {`IO_REGION, `IO_OFS_TMR};
    localparam io_addr_t ADDR_SPI_CTRL = {`IO_REGION, `IO_OFS_SPI_CTRL};
    localparam io_addr_t ADDR_SPI_DATA = {`IO_REGION, `IO_OFS_SPI_DATA};
    localparam io_addr_t ADDR_UNMAPPED = {`IO_REGION, 28'h000_0010};
    localparam io_addr_t ADDR_OUTSIDE  = 32'h8000_0004;

    localparam int READY_TIMEOUT = 10;
    localparam int POLL_LIMIT    = 40;
    localparam int TMR_WAIT      = 500;

    logic        clk_48;
    logic        rst_n;
    io_req_t     io_req;
    logic        io_ready;
    io_data_t    io_read_data;
    led_bits_t   led;
    logic        spi_cs;
    logic        spi_clk;
    logic        spi_mosi;
    logic        spi_miso;

    int          value_errors = 0;
    int          timeout_errors = 0;
    int unsigned cycle_cnt = 0;
    int unsigned ready_cycle;
    logic [15:0] lfsr_state;
    logic        region_access;

    // SPI pin monitor
    int          pulse_cnt = 0;
    spi_byte_t   mosi_bits = '0;
    logic        spi_clk_prev = 1'b1;

    // Loopback, every byte sent comes back
    assign spi_miso = spi_mosi;

    cpu_io_block i_cpu_io_block (
        .clk_48       (clk_48),
        .rst_n        (rst_n),
        .io_req       (io_req),
        .io_ready     (io_ready),
        .io_read_data (io_read_data),
        .led          (led),
        .spi_cs       (spi_cs),
        .spi_clk      (spi_clk),
        .spi_mosi     (spi_mosi),
        .spi_miso     (spi_miso)
    );

    initial clk_48 = 1'b0;
    always #20 clk_48 = ~clk_48;

    always @(posedge clk_48) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    assign region_access = io_req.addr_strobe &&
                           (io_req.address[31:28] == `IO_REGION) &&
                           (io_req.read_strobe || io_req.write_strobe);

    // --------------------------------------------------
    // Bus and SPI pin assertions
    // --------------------------------------------------

    assert property (@(posedge clk_48) disable iff (!rst_n) region_access |=> io_ready)
        else begin
            value_errors++;
            $display("[FAIL] %0t io_ready expected 1 got 0", $time);
        end

    assert property (@(posedge clk_48) disable iff (!rst_n) !region_access |=> !io_ready)
        else begin
            value_errors++;
            $display("[FAIL] %0t io_ready expected 0 got 1", $time);
        end

    // Low phase of the SPI clock is one cycle
    assert property (@(posedge clk_48) disable iff (!rst_n) !spi_clk |=> spi_clk)
        else begin
            value_errors++;
            $display("[FAIL] %0t spi_clk expected 1 got 0", $time);
        end

    always @(negedge clk_48) begin
        if (rst_n && spi_clk_prev && !spi_clk) begin
            pulse_cnt = pulse_cnt + 1;
            mosi_bits = {mosi_bits[6:0], spi_mosi};
        end
        spi_clk_prev = spi_clk;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("[FAIL] %0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        end
    endtask

    // Returns on the rising edge after ready, data captured mid-cycle
    task automatic wait_ready(input io_addr_t addr, output io_data_t data);
        int  cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        data = '0;
        while (!seen && cycles < READY_TIMEOUT) begin
            @(negedge clk_48);
            cycles++;
            if (io_ready) begin
                seen = 1'b1;
                data = io_read_data;
                ready_cycle = cycle_cnt;
            end
        end
        if (!seen) begin
            timeout_errors++;
            $display("Timeout: no io_ready within %0d cycles for address 0x%h",
                     READY_TIMEOUT, addr);
        end
        @(posedge clk_48);
    endtask

    task automatic bus_write(input io_addr_t addr, input io_data_t data);
        io_req_t  req;
        io_data_t unused;
        req = '0;
        req.addr_strobe  = 1'b1;
        req.write_strobe = 1'b1;
        req.address      = addr;
        req.write_data   = data;
        io_req <= req;
        @(posedge clk_48);
        io_req <= '0;
        wait_ready(addr, unused);
    endtask

    task automatic bus_read(input io_addr_t addr, output io_data_t data);
        io_req_t req;
        req = '0;
        req.addr_strobe = 1'b1;
        req.read_strobe = 1'b1;
        req.address     = addr;
        io_req <= req;
        @(posedge clk_48);
        io_req <= '0;
        wait_ready(addr, data);
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    initial begin
        io_data_t    rd_data;
        logic [31:0] rnd;
        io_data_t    tmr_first;
        int unsigned cyc_first;
        int          tick_exp;
        int          tick_diff;
        spi_byte_t   tx_byte;
        int          polls;
        io_req_t     req;

        rst_n = 1'b0;
        io_req = '0;
        lfsr_state = 16'd26;

        repeat (4) @(posedge clk_48);
        rst_n <= 1'b1;

        // Reset values, then a quiet bus
        @(negedge clk_48);
        check_equal("led", 32'(`LED_RESET), 32'(led));
        check_equal("spi_cs", 32'd1, 32'(spi_cs));
        check_equal("spi_clk", 32'd1, 32'(spi_clk));
        check_equal("spi_mosi", 32'd1, 32'(spi_mosi));
        repeat (8) @(posedge clk_48);

        bus_read(ADDR_UNMAPPED, rd_data);
        check_equal("io_read_data unmapped", 32'd0, rd_data);

        // Outside the region, no ready at all
        req = '0;
        req.addr_strobe = 1'b1;
        req.read_strobe = 1'b1;
        req.address     = ADDR_OUTSIDE;
        io_req <= req;
        @(posedge clk_48);
        io_req <= '0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk_48);
            check_equal("io_ready outside region", 32'd0, 32'(io_ready));
        end
        @(posedge clk_48);

        // Random LED writes
        for (int i = 0; i < 8; i++) begin
            random_bits(32, rnd);
            bus_write(ADDR_LED, rnd);
            @(negedge clk_48);
            check_equal("led", {29'b0, rnd[2:0]}, 32'(led));
            @(posedge clk_48);
            bus_read(ADDR_LED, rd_data);
            check_equal("io_read_data led", {29'b0, rnd[2:0]}, rd_data);
        end

        // Timer
        bus_read(ADDR_TMR, tmr_first);
        cyc_first = ready_cycle;
        repeat (TMR_WAIT) @(posedge clk_48);
        bus_read(ADDR_TMR, rd_data);
        tick_exp  = int'(ready_cycle - cyc_first) / `TMR_PRESCALE;
        tick_diff = int'(rd_data - tmr_first);
        assert ((tick_diff >= tick_exp - 1) && (tick_diff <= tick_exp + 1)) else begin
            value_errors++;
            $display("[FAIL] %0t io_read_data timer delta expected %0d got %0d",
                     $time, tick_exp, tick_diff);
        end

        // Chip select
        bus_write(ADDR_SPI_CTRL, 32'd0);
        @(negedge clk_48);
        check_equal("spi_cs", 32'd0, 32'(spi_cs));
        @(posedge clk_48);
        bus_read(ADDR_SPI_CTRL, rd_data);
        check_equal("io_read_data spi ctrl", 32'd0, rd_data);

        // Looped back byte transfers
        for (int i = 0; i < 4; i++) begin
            random_bits(8, rnd);
            tx_byte = rnd[7:0];
            pulse_cnt = 0;
            mosi_bits = '0;
            bus_write(ADDR_SPI_DATA, {24'b0, tx_byte});
            bus_read(ADDR_SPI_CTRL, rd_data);
            check_equal("spi busy", 32'd1, 32'(rd_data[1]));
            polls = 0;
            while (rd_data[1] && polls < POLL_LIMIT) begin
                check_equal("spi cs readback", 32'd0, 32'(rd_data[0]));
                bus_read(ADDR_SPI_CTRL, rd_data);
                polls++;
            end
            if (rd_data[1]) begin
                timeout_errors++;
                $display("Timeout: SPI still busy after %0d control reads", POLL_LIMIT);
            end
            check_equal("spi_clk pulses", 32'd8, 32'(pulse_cnt));
            check_equal("spi_mosi bits", 32'(tx_byte), 32'(mosi_bits));
            bus_read(ADDR_SPI_DATA, rd_data);
            check_equal("io_read_data spi data", 32'(tx_byte), rd_data);
        end

        bus_write(ADDR_SPI_CTRL, 32'd1);
        @(negedge clk_48);
        check_equal("spi_cs", 32'd1, 32'(spi_cs));
        @(posedge clk_48);
        bus_read(ADDR_SPI_CTRL, rd_data);
        check_equal("io_read_data spi ctrl", 32'd1, rd_data);

        repeat (4) @(posedge clk_48);
        $display("Error counts: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
rtl/io_pkg.sv
rtl/io_decoder.sv
rtl/sys_regs.sv
rtl/spi_master.sv
rtl/cpu_io_block.sv
test/tb_cpu_io_block.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_cpu_io_block \
    && ./obj_dir/Vtb_cpu_io_block | tee sim.log

grep -q "^Done: no errors$" sim.log 2>/dev/null && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
